// ==== design/delay_line.sv ====
`default_nettype none

module delay_line #(
    parameter type T     = logic,
    parameter int  DEPTH = 1
) (
    input  wire  clk_i,
    input  wire  arst_n_i,
    input  wire  T d_i,
    output T       q_o
);

    T stage_q [DEPTH];

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < DEPTH; i++) begin
                stage_q[i] <= '0;
            end
        end else begin
            stage_q[0] <= d_i;
            for (int i = 1; i < DEPTH; i++) begin
                stage_q[i] <= stage_q[i-1];
            end
        end
    end

    // oldest stage is the output
    assign q_o = stage_q[DEPTH-1];

endmodule

`default_nettype wire

// ==== design/l2_pkg.sv ====
`default_nettype none

package l2_pkg;

    localparam int NTIO    = 4;
    localparam int NPOL    = 2;
    localparam int NSECT   = 12;
    localparam int NREGION = 4;
    localparam int NSLOT   = 6;

    localparam int META_W = 64;
    localparam int TRIG_W = 8;
    localparam int SLOT_W = 8;

    // trigger word bits
    localparam int LF_BIT  = 6;
    localparam int AUX_BIT = 7;

    // mask bits above the sector masks disable the two LF triggers
    localparam int MASK_LF_LSB = NPOL*NSECT + 2;

    typedef logic [META_W-1:0]             meta_t;
    typedef logic [NTIO-1:0][META_W-1:0]   tio_meta_t;
    typedef logic [NTIO-1:0][TRIG_W-1:0]   tio_trig_t;
    typedef logic [NSECT*NREGION-1:0]      sector_bits_t;
    typedef logic [MASK_LF_LSB+1:0]        mask_t;
    typedef logic [NPOL*NSECT-1:0]         l2_scaler_t;

    typedef struct packed {
        logic       aux;
        logic [1:0] lf;
    } side_trig_t;

    // low and high threshold region bits, both in sector order
    typedef struct packed {
        sector_bits_t high;
        sector_bits_t low;
    } thr_bits_t;

    // sectors 0..5 walk the reversed word from slot 5 down,
    // sectors 6..11 walk the forward word from slot 0 up
    function automatic sector_bits_t map_sectors(meta_t rev, meta_t fwd, logic high);
        sector_bits_t bits;
        int unsigned  off;
        off = high ? NREGION : 0;
        for (int i = 0; i < NSECT; i++) begin
            if (i < NSLOT) begin
                bits[NREGION*i +: NREGION] = rev[SLOT_W*(NSLOT-1-i) + off +: NREGION];
            end else begin
                bits[NREGION*i +: NREGION] = fwd[SLOT_W*(i-NSLOT) + off +: NREGION];
            end
        end
        return bits;
    endfunction

endpackage

`default_nettype wire

// ==== design/leveltwo_top.sv ====
`default_nettype none

module leveltwo_top
    import l2_pkg::*;
#(
    parameter int META_DELAY = 4
) (
    input  wire  logic       clk_i,
    input  wire  logic       arst_n_i,
    input  wire  tio_trig_t  tio_trig_i,
    input  wire  tio_meta_t  tio_meta_i,
    input  wire  logic       holdoff_i,
    input  wire  logic       dead_i,
    input  wire  logic       logictype_i,
    input  wire  logic       rf_en_i,
    input  wire  mask_t      mask_i,
    output tio_meta_t        tio_meta_o,
    output l2_scaler_t       leveltwo_o,
    output logic [NPOL-1:0]  mie_o,
    output logic [1:0]       lf_o,
    output logic             aux_o,
    output logic             levelthree_o,
    output logic             trig_o
);

    l2_scaler_t      sector_hit;
    logic [NPOL-1:0] pol_trig;

    // metadata follows the trigger out
    delay_line #(
        .T     (tio_meta_t),
        .DEPTH (META_DELAY)
    ) u_meta_dly (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .d_i      (tio_meta_i),
        .q_o      (tio_meta_o)
    );

    // hpol sees tio0 reversed and tio1 forward
    rf_coincidence u_hpol (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .meta_rev_i    (tio_meta_i[0]),
        .meta_fwd_i    (tio_meta_i[1]),
        .sector_mask_i (mask_i[NSECT-1:0]),
        .logictype_i   (logictype_i),
        .sector_hit_o  (sector_hit[NSECT-1:0]),
        .pol_trig_o    (pol_trig[0])
    );

    // vpol sees tio3 reversed and tio2 forward
    rf_coincidence u_vpol (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .meta_rev_i    (tio_meta_i[3]),
        .meta_fwd_i    (tio_meta_i[2]),
        .sector_mask_i (mask_i[2*NSECT-1:NSECT]),
        .logictype_i   (logictype_i),
        .sector_hit_o  (sector_hit[2*NSECT-1:NSECT]),
        .pol_trig_o    (pol_trig[1])
    );

    sector_scaler u_scaler (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .sector_hit_i (sector_hit),
        .leveltwo_o   (leveltwo_o)
    );

    trigger_combiner u_combiner (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .pol_trig_i   (pol_trig),
        .tio_trig_i   (tio_trig_i),
        .rf_en_i      (rf_en_i),
        .lf_mask_i    (mask_i[MASK_LF_LSB +: 2]),
        .holdoff_i    (holdoff_i),
        .dead_i       (dead_i),
        .mie_o        (mie_o),
        .lf_o         (lf_o),
        .aux_o        (aux_o),
        .trig_o       (trig_o),
        .levelthree_o (levelthree_o)
    );

endmodule

`default_nettype wire

// ==== design/rf_coincidence.sv ====
`default_nettype none

module rf_coincidence
    import l2_pkg::*;
(
    input  wire  logic             clk_i,
    input  wire  logic             arst_n_i,
    input  wire  meta_t            meta_rev_i,
    input  wire  meta_t            meta_fwd_i,
    input  wire  logic [NSECT-1:0] sector_mask_i,
    input  wire  logic             logictype_i,
    output logic [NSECT-1:0]       sector_hit_o,
    output logic                   pol_trig_o
);

    thr_bits_t    map_d;
    thr_bits_t    map_q;
    thr_bits_t    map_qq;
    thr_bits_t    stretch_q;
    sector_bits_t high_rot;
    sector_bits_t mask_bits;
    sector_bits_t coinc_d;
    sector_bits_t coinc_q;

    assign map_d.low  = map_sectors(meta_rev_i, meta_fwd_i, 1'b0);
    assign map_d.high = map_sectors(meta_rev_i, meta_fwd_i, 1'b1);

    // sector i looks at the high bits of its right neighbour, 11 wraps to 0
    assign high_rot = {stretch_q.high[NREGION-1:0], stretch_q.high[NSECT*NREGION-1:NREGION]};

    always_comb begin
        for (int i = 0; i < NSECT; i++) begin
            mask_bits[NREGION*i +: NREGION] = {NREGION{sector_mask_i[i]}};
        end
    end

    // logictype 0 needs low and high together, 1 takes either
    assign coinc_d = (logictype_i ? (stretch_q.low | high_rot)
                                  : (stretch_q.low & high_rot)) & ~mask_bits;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            map_q     <= '0;
            map_qq    <= '0;
            stretch_q <= '0;
            coinc_q   <= '0;
        end else begin
            map_q     <= map_d;
            map_qq    <= map_q;
            // two-cycle coincidence window
            stretch_q <= map_q | map_qq;
            coinc_q   <= coinc_d;
        end
    end

    always_comb begin
        for (int i = 0; i < NSECT; i++) begin
            sector_hit_o[i] = |coinc_q[NREGION*i +: NREGION];
        end
    end

    assign pol_trig_o = |coinc_q;

endmodule

`default_nettype wire

// ==== design/sector_scaler.sv ====
`default_nettype none

module sector_scaler
    import l2_pkg::*;
(
    input  wire  logic       clk_i,
    input  wire  logic       arst_n_i,
    input  wire  l2_scaler_t sector_hit_i,
    output l2_scaler_t       leveltwo_o
);

    l2_scaler_t hit_q;
    l2_scaler_t hit_qq;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            hit_q      <= '0;
            hit_qq     <= '0;
            leveltwo_o <= '0;
        end else begin
            hit_q      <= sector_hit_i;
            hit_qq     <= hit_q;
            // one pulse per rising edge, so a long hit counts once
            leveltwo_o <= hit_q & ~hit_qq;
        end
    end

endmodule

`default_nettype wire

// ==== design/trigger_combiner.sv ====
`default_nettype none

module trigger_combiner
    import l2_pkg::*;
(
    input  wire  logic            clk_i,
    input  wire  logic            arst_n_i,
    input  wire  logic [NPOL-1:0] pol_trig_i,
    input  wire  tio_trig_t       tio_trig_i,
    input  wire  logic            rf_en_i,
    input  wire  logic [1:0]      lf_mask_i,
    input  wire  logic            holdoff_i,
    input  wire  logic            dead_i,
    output logic [NPOL-1:0]       mie_o,
    output logic [1:0]            lf_o,
    output logic                  aux_o,
    output logic                  trig_o,
    output logic                  levelthree_o
);

    localparam int POR_LEN = 4;

    logic [POR_LEN-1:0] por_q;
    logic               por_done;
    logic [NPOL-1:0]    leveltwo_q;
    side_trig_t         side_d;
    side_trig_t         side_q;
    side_trig_t         side_dly;
    logic               trig_q;

    // RF coincidence registers start empty, hold off until the pipe has filled
    assign por_done = por_q[POR_LEN-1];

    always_comb begin
        side_d.aux = 1'b0;
        for (int t = 0; t < NTIO; t++) begin
            side_d.aux = side_d.aux | tio_trig_i[t][AUX_BIT];
        end
        // left LF from tio0/tio2, right LF from tio1/tio3
        side_d.lf[0] = (tio_trig_i[0][LF_BIT] | tio_trig_i[2][LF_BIT]) & rf_en_i & ~lf_mask_i[0];
        side_d.lf[1] = (tio_trig_i[1][LF_BIT] | tio_trig_i[3][LF_BIT]) & rf_en_i & ~lf_mask_i[1];
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            por_q      <= '0;
            leveltwo_q <= '0;
            side_q     <= '0;
            trig_q     <= 1'b0;
        end else begin
            por_q      <= {por_q[POR_LEN-2:0], 1'b1};
            leveltwo_q <= pol_trig_i & {NPOL{por_done & rf_en_i}};
            side_q     <= side_d;
            trig_q     <= ~holdoff_i & ~dead_i
                          & (side_dly.aux | (|side_dly.lf) | (|leveltwo_q));
        end
    end

    // aux and LF wait two more cycles to meet the RF path
    delay_line #(
        .T     (side_trig_t),
        .DEPTH (2)
    ) u_side_dly (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .d_i      (side_q),
        .q_o      (side_dly)
    );

    assign trig_o       = trig_q;
    assign levelthree_o = trig_q;

    // scalers still count while dead, only holdoff blocks them
    assign mie_o = leveltwo_q & {NPOL{~holdoff_i}};
    assign lf_o  = side_dly.lf & {2{~holdoff_i}};
    assign aux_o = side_dly.aux & ~holdoff_i;

endmodule

`default_nettype wire

// ==== src.f ====
design/l2_pkg.sv
design/delay_line.sv
design/rf_coincidence.sv
design/sector_scaler.sv
design/trigger_combiner.sv
design/leveltwo_top.sv
tests/tb_clock_gen.sv
tests/leveltwo_sva.sv
tests/tb_leveltwo.sv

// ==== tests/leveltwo_sva.sv ====
`default_nettype none

module leveltwo_sva
    import l2_pkg::*;
(
    input  wire  logic            clk_i,
    input  wire  logic            arst_n_i,
    input  wire  logic            holdoff_i,
    input  wire  logic            dead_i,
    input  wire  logic            trig_o,
    input  wire  logic [NPOL-1:0] mie_o,
    input  wire  logic [1:0]      lf_o,
    input  wire  logic            aux_o,
    input  wire  l2_scaler_t      leveltwo_o
);

    // master trigger was formed in an open cycle
    trig_open_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        trig_o |-> $past(!holdoff_i && !dead_i))
        else $error("trig_o high although holdoff or dead was set one cycle earlier");

    holdoff_quiet_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        holdoff_i |-> (mie_o == '0 && lf_o == '0 && !aux_o))
        else $error("scaler outputs active during holdoff");

    // edge pulses never last two cycles
    pulse_single_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (|leveltwo_o) |-> ((leveltwo_o & $past(leveltwo_o)) == '0))
        else $error("leveltwo_o bit high two cycles in a row");

endmodule

bind leveltwo_top leveltwo_sva u_sva (.*);

`default_nettype wire

// ==== tests/tb_clock_gen.sv ====
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD = 8
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
        forever begin
            #(PERIOD/2) clk_o = ~clk_o;
        end
    end

endmodule

`default_nettype wire

// ==== tests/tb_leveltwo.sv ====
`default_nettype none

module tb_leveltwo
    import l2_pkg::*;
();

    logic       clk_i;
    logic       arst_n_i;
    tio_trig_t  tio_trig_i;
    tio_meta_t  tio_meta_i;
    logic       holdoff_i;
    logic       dead_i;
    logic       logictype_i;
    logic       rf_en_i;
    mask_t      mask_i;
    tio_meta_t  tio_meta_o;
    l2_scaler_t leveltwo_o;
    logic [1:0] mie_o;
    logic [1:0] lf_o;
    logic       aux_o;
    logic       levelthree_o;
    logic       trig_o;

    int unsigned n_checks = 0;
    int unsigned n_errors = 0;
    logic        ho_on = 1'b0;
    logic        dead_on = 1'b0;
    int          n;

    // cycle model state with one entry per pipeline register
    tio_meta_t   m_meta [4] = '{default: '0};
    logic [47:0] m_lo_q [2] = '{default: '0};
    logic [47:0] m_lo_qq [2] = '{default: '0};
    logic [47:0] m_hi_q [2] = '{default: '0};
    logic [47:0] m_hi_qq [2] = '{default: '0};
    logic [47:0] m_lo_s [2] = '{default: '0};
    logic [47:0] m_hi_s [2] = '{default: '0};
    logic [47:0] m_coinc [2] = '{default: '0};
    side_trig_t  m_side [3] = '{default: '0};
    l2_scaler_t  m_hq = '0;
    l2_scaler_t  m_hqq = '0;
    l2_scaler_t  m_l2 = '0;
    logic [3:0]  m_por = '0;
    logic [1:0]  m_lt = '0;
    logic        m_trig = 1'b0;

    tb_clock_gen #(.PERIOD(8)) u_clk (.clk_o(clk_i));

    leveltwo_top #(.META_DELAY(4)) DUT (.*);

    // slot s of the reversed word feeds sector 5-s and of the forward word sector 6+s
    function automatic logic [47:0] sector_order(logic [63:0] rev, logic [63:0] fwd, int nib);
        logic [47:0] r;
        for (int s = 0; s < 6; s++) begin
            r[4*(5-s) +: 4] = rev[8*s + 4*nib +: 4];
            r[4*(6+s) +: 4] = fwd[8*s + 4*nib +: 4];
        end
        return r;
    endfunction

    // about one bit in sixteen set
    function automatic logic [63:0] sparse_word();
        logic [63:0] r;
        r = '1;
        for (int k = 0; k < 4; k++)
            r = r & {$urandom, $urandom};
        return r;
    endfunction

    task automatic model_step();
        logic [47:0] rot;
        logic [47:0] comb;
        l2_scaler_t  hits;
        side_trig_t  side_new;
        m_trig = ~holdoff_i & ~dead_i & (m_side[2].aux | (|m_side[2].lf) | (|m_lt));
        side_new.aux = tio_trig_i[0][7] | tio_trig_i[1][7] | tio_trig_i[2][7] | tio_trig_i[3][7];
        side_new.lf[0] = (tio_trig_i[0][6] | tio_trig_i[2][6]) & rf_en_i & ~mask_i[26];
        side_new.lf[1] = (tio_trig_i[1][6] | tio_trig_i[3][6]) & rf_en_i & ~mask_i[27];
        m_side[2] = m_side[1];
        m_side[1] = m_side[0];
        m_side[0] = side_new;
        m_lt = {|m_coinc[1], |m_coinc[0]} & {2{m_por[3] & rf_en_i}};
        m_por = {m_por[2:0], 1'b1};
        for (int i = 0; i < 24; i++)
            hits[i] = |m_coinc[i/12][4*(i%12) +: 4];
        m_l2 = m_hq & ~m_hqq;
        m_hqq = m_hq;
        m_hq = hits;
        for (int p = 0; p < 2; p++) begin
            // sector i pairs with the high bits of sector i+1
            for (int i = 0; i < 12; i++)
                rot[4*i +: 4] = m_hi_s[p][4*((i+1)%12) +: 4];
            comb = logictype_i ? (m_lo_s[p] | rot) : (m_lo_s[p] & rot);
            for (int i = 0; i < 12; i++)
                if (mask_i[12*p + i]) comb[4*i +: 4] = 4'h0;
            m_coinc[p] = comb;
            m_lo_s[p] = m_lo_q[p] | m_lo_qq[p];
            m_hi_s[p] = m_hi_q[p] | m_hi_qq[p];
            m_lo_qq[p] = m_lo_q[p];
            m_hi_qq[p] = m_hi_q[p];
            m_lo_q[p] = sector_order(tio_meta_i[p ? 3 : 0], tio_meta_i[p ? 2 : 1], 0);
            m_hi_q[p] = sector_order(tio_meta_i[p ? 3 : 0], tio_meta_i[p ? 2 : 1], 1);
        end
        for (int k = 3; k > 0; k--)
            m_meta[k] = m_meta[k-1];
        m_meta[0] = tio_meta_i;
    endtask

    task automatic check_val(input string name, input logic [255:0] exp_v,
                             input logic [255:0] act_v);
        n_checks++;
        if (act_v !== exp_v) begin
            n_errors++;
            $display("error: %s expected %0h got %0h at time %0t", name, exp_v, act_v, $time);
        end
    endtask

    task automatic drive_inputs();
        for (int t = 0; t < 4; t++) begin
            tio_meta_i[t] = sparse_word();
            tio_trig_i[t] = 8'($urandom & $urandom & $urandom & $urandom);
        end
        holdoff_i = ho_on && ($urandom % 4 == 0);
        dead_i = dead_on && ($urandom % 4 == 0);
    endtask

    // model steps at the edge and outputs are compared once they settle
    task automatic run_cycle();
        @(posedge clk_i);
        model_step();
        #1;
        check_val("tio_meta_o", m_meta[3], tio_meta_o);
        check_val("leveltwo_o", m_l2, leveltwo_o);
        check_val("mie_o", m_lt & {2{~holdoff_i}}, mie_o);
        check_val("lf_o", m_side[2].lf & {2{~holdoff_i}}, lf_o);
        check_val("aux_o", m_side[2].aux & ~holdoff_i, aux_o);
        check_val("trig_o", m_trig, trig_o);
        check_val("levelthree_o", m_trig, levelthree_o);
        drive_inputs();
    endtask

    initial begin
        #(8 * 4000);
        $display("timeout: simulation did not finish in time");
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        void'($urandom(32'hc4ba75fe));
        arst_n_i = 1'b0;
        tio_trig_i = '0;
        tio_meta_i = '0;
        holdoff_i = 1'b0;
        dead_i = 1'b0;
        logictype_i = 1'b0;
        rf_en_i = 1'b1;
        mask_i = '0;
        n = 0;
        while (n < 2) begin
            @(posedge clk_i);
            n++;
        end
        #1;
        arst_n_i = 1'b1;
        drive_inputs();
        // a dense first word hits every sector while por is still low
        tio_meta_i = '1;
        n = 0;
        while (trig_o !== 1'b1 && n < 100) begin
            run_cycle();
            n++;
        end
        if (trig_o !== 1'b1) begin
            n_errors++;
            $display("no trigger seen within 100 cycles after reset");
        end
        // even phases run AND mode and odd phases OR mode
        for (int ph = 0; ph < 6; ph++) begin
            logictype_i = ph[0];
            mask_i = (ph < 2) ? '0 : mask_t'($urandom & $urandom);
            // each LF mask bit gets a phase with rf_en high
            mask_i[MASK_LF_LSB +: 2] = ph[1:0];
            rf_en_i = (ph != 3);
            ho_on = (ph >= 2);
            dead_on = (ph >= 4);
            for (int c = 0; c < 300; c++)
                run_cycle();
        end
        $display("checks: %0d  errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire
